/* design/rsync_pkg.sv */
`default_nettype none

package rsync_pkg;

    // Lane counts
    localparam int num_bin_lanes   = 7;                        // Lane 0 is the redundant bit
    localparam int num_therm_lanes = 17;
    localparam int num_lanes       = num_bin_lanes + num_therm_lanes;
    localparam int num_trims       = 2 * num_lanes;            // True lanes, then complement lanes

    // Widths
    localparam int level_w     = 8;
    localparam int trim_w      = 6;
    localparam int trim_addr_w = 6;
    localparam int meas_w      = 10;

    localparam logic [level_w-1:0] lane_unit = 8'd128;         // Nominal level for a set bit

    // First trim address of the complement lanes
    localparam logic [trim_addr_w-1:0] comp_base = 6'd32;

    // Supply windows
    localparam logic [meas_w-1:0]        vdd_min  = 10'd760;   // mV, 0.8 V -5 %
    localparam logic [meas_w-1:0]        vdd_max  = 10'd840;   // mV, 0.8 V +5 %
    localparam logic signed [meas_w-1:0] vss_min  = -10'sd50;  // mV
    localparam logic signed [meas_w-1:0] vss_max  = 10'sd50;   // mV
    localparam logic [meas_w-1:0]        iref_min = 10'd225;   // 0.1 uA, 25 uA -10 %
    localparam logic [meas_w-1:0]        iref_max = 10'd275;   // 0.1 uA, 25 uA +10 %

    // Test bus select codes
    localparam logic [1:0] atb_off       = 2'b00;
    localparam logic [1:0] atb_vdd_vss_a = 2'b01;
    localparam logic [1:0] atb_vdd_vss_b = 2'b10;
    localparam logic [1:0] atb_iref      = 2'b11;

    typedef logic [level_w-1:0]       level_t;
    typedef logic signed [trim_w-1:0] trim_t;
    typedef trim_t [num_trims-1:0]    trim_array_t;            // Index is the write slot

    typedef struct packed {
        logic [num_therm_lanes-1:0] therm;                     // Upper bits
        logic [num_bin_lanes-1:0]   bin;                       // Lower bits
    } lane_split_t;

    // Flat view is indexed by lane, split view by group
    typedef union packed {
        logic [num_lanes-1:0] flat;
        lane_split_t          split;
    } lane_word_u;

    typedef struct packed {
        logic [meas_w-1:0]        vdd_code;
        logic signed [meas_w-1:0] vss_code;
        logic [meas_w-1:0]        iref_code;
    } supply_meas_t;

    typedef struct packed {
        logic vdd_ok;
        logic vss_ok;
        logic iref_ok;
    } supply_status_t;

    typedef struct packed {
        logic                   wr;                            // Single-cycle strobe
        logic [trim_addr_w-1:0] addr;
        trim_t                  data;
    } trim_wr_t;

    typedef struct packed {
        level_t [num_bin_lanes-1:0]   bin;
        level_t [num_bin_lanes-1:0]   bin_b;
        level_t [num_therm_lanes-1:0] therm;
        level_t [num_therm_lanes-1:0] therm_b;
    } drive_levels_t;

    typedef struct packed {
        logic [meas_w-1:0] atb1;
        logic [meas_w-1:0] atb0;
    } atb_t;

endpackage

`default_nettype wire

/* design/supply_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

module supply_monitor import rsync_pkg::*; (
    input  wire logic           clkin_binary_0,
    input  wire logic           clkinb_binary_0,   // Async reset, active low
    input  wire supply_meas_t   meas,
    output supply_status_t      status,
    output logic                supply_ok
);

    supply_status_t status_next;

    // Window checks, edges included
    always_comb begin
        status_next.vdd_ok = (meas.vdd_code >= vdd_min) &&
                             (meas.vdd_code <= vdd_max);
        status_next.vss_ok = ($signed(meas.vss_code) >= vss_min) &&   // Signed compare
                             ($signed(meas.vss_code) <= vss_max);
        status_next.iref_ok = (meas.iref_code >= iref_min) &&
                              (meas.iref_code <= iref_max);
    end

    always_ff @(posedge clkin_binary_0 or negedge clkinb_binary_0) begin
        if (!clkinb_binary_0) begin
            status <= '0;                                  // All readings flagged bad
        end else begin
            status <= status_next;
        end
    end

    // All three readings must sit inside their window
    assign supply_ok = status.vdd_ok & status.vss_ok & status.iref_ok;

endmodule

`default_nettype wire

/* design/trim_table.sv */
`timescale 1ns/1ps
`default_nettype none

module trim_table import rsync_pkg::*; (
    input  wire logic       clkin_binary_0,
    input  wire logic       clkinb_binary_0,
    input  wire trim_wr_t   trim_wr,
    output trim_array_t     trims
);

    logic                   is_comp;
    logic [trim_addr_w-1:0] lane_idx;
    logic [trim_addr_w-1:0] slot;
    logic                   addr_ok;

    // Address decode
    always_comb begin
        is_comp  = (trim_wr.addr >= comp_base);               // Complement half
        lane_idx = is_comp ? trim_wr.addr - comp_base : trim_wr.addr;
        addr_ok  = (lane_idx < trim_addr_w'(num_lanes));      // Holes at 24-31 and 56-63
        slot     = is_comp ? lane_idx + trim_addr_w'(num_lanes) : lane_idx;
    end

    always_ff @(posedge clkin_binary_0 or negedge clkinb_binary_0) begin
        if (!clkinb_binary_0) begin
            trims <= '0;                                       // No mismatch out of reset
        end else if (trim_wr.wr && addr_ok) begin
            trims[slot] <= trim_wr.data;
        end
    end

endmodule

`default_nettype wire

/* design/lane_latch_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module lane_latch_bank import rsync_pkg::*; (
    input  wire logic           clkin_binary_0,
    input  wire logic           clkinb_binary_0,
    input  wire lane_word_u     data_in,
    input  wire lane_word_u     data_in_b,
    input  wire logic           pdb,             // Power down, active low
    input  wire logic           supply_ok,
    input  wire trim_array_t    trims,
    output drive_levels_t       levels,
    output logic                lanes_active
);

    drive_levels_t levels_next;

    // Drive level of one switch: unit plus trim when set, else off
    function automatic level_t lane_level(input logic lane_bit, input trim_t trim);
        level_t trim_ext;
        trim_ext = {{(level_w-trim_w){trim[trim_w-1]}}, trim};   // Sign extend
        if (lane_bit) begin
            return lane_unit + trim_ext;
        end
        return '0;
    endfunction

    // Trim slots follow the flat lane index, complement lanes sit num_lanes above
    always_comb begin
        for (int b = 0; b < num_bin_lanes; b++) begin
            levels_next.bin[b]   = lane_level(data_in.split.bin[b], trims[b]);
            levels_next.bin_b[b] = lane_level(data_in_b.split.bin[b],
                                              trims[num_lanes + b]);
        end
        for (int t = 0; t < num_therm_lanes; t++) begin
            levels_next.therm[t]   = lane_level(data_in.split.therm[t],
                                                trims[num_bin_lanes + t]);
            levels_next.therm_b[t] = lane_level(data_in_b.split.therm[t],
                                                trims[num_lanes + num_bin_lanes + t]);
        end
    end

    // Resync register with power-down and supply gating
    always_ff @(posedge clkin_binary_0 or negedge clkinb_binary_0) begin
        if (!clkinb_binary_0) begin
            levels       <= '0;
            lanes_active <= 1'b0;
        end else if (!pdb) begin
            levels       <= '0;                  // Powered down, all switches off
            lanes_active <= 1'b0;
        end else if (supply_ok) begin
            levels       <= levels_next;
            lanes_active <= 1'b1;
        end
        // Supplies out of window: hold last levels
    end

endmodule

`default_nettype wire

/* design/test_bus_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module test_bus_mux import rsync_pkg::*; (
    input  wire logic           clkin_binary_0,
    input  wire logic           clkinb_binary_0,
    input  wire supply_meas_t   meas,
    input  wire logic [1:0]     atb_ena,
    input  wire logic           pdb,
    input  wire logic           supply_ok,
    output atb_t                atb,
    output logic                atb_valid
);

    atb_t atb_next;
    logic valid_next;

    always_comb begin
        atb_next   = '0;                         // Idle bus
        valid_next = 1'b0;
        if (pdb && supply_ok) begin
            case (atb_ena)
                atb_vdd_vss_a, atb_vdd_vss_b: begin
                    atb_next.atb1 = meas.vdd_code;
                    atb_next.atb0 = meas.vss_code;
                    valid_next    = 1'b1;
                end
                atb_iref: begin
                    atb_next.atb1 = meas.iref_code;   // Same reading on both legs
                    atb_next.atb0 = meas.iref_code;
                    valid_next    = 1'b1;
                end
                atb_off: begin
                    valid_next = 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clkin_binary_0 or negedge clkinb_binary_0) begin
        if (!clkinb_binary_0) begin
            atb       <= '0;
            atb_valid <= 1'b0;
        end else begin
            atb       <= atb_next;
            atb_valid <= valid_next;
        end
    end

endmodule

`default_nettype wire

/* design/rsync_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rsync_top import rsync_pkg::*; (
    input  wire logic           clkin_binary_0,    // Shared lane clock
    input  wire logic           clkinb_binary_0,   // Async reset, active low
    input  wire lane_word_u     data_in,
    input  wire lane_word_u     data_in_b,
    input  wire logic           pdb,
    input  wire supply_meas_t   meas,
    input  wire trim_wr_t       trim_wr,
    input  wire logic [1:0]     atb_ena,
    output drive_levels_t       levels,
    output logic                lanes_active,
    output logic                supply_ok,
    output atb_t                atb,
    output logic                atb_valid
);

    trim_array_t trims;

    // Per-reading flags stay inside the monitor, only the conjunction leaves
    supply_monitor u_supply_monitor (
        .clkin_binary_0  (clkin_binary_0),
        .clkinb_binary_0 (clkinb_binary_0),
        .meas            (meas),
        .status          (),
        .supply_ok       (supply_ok)
    );

    trim_table u_trim_table (
        .clkin_binary_0  (clkin_binary_0),
        .clkinb_binary_0 (clkinb_binary_0),
        .trim_wr         (trim_wr),
        .trims           (trims)
    );

    lane_latch_bank u_lane_latch_bank (
        .clkin_binary_0  (clkin_binary_0),
        .clkinb_binary_0 (clkinb_binary_0),
        .data_in         (data_in),
        .data_in_b       (data_in_b),
        .pdb             (pdb),
        .supply_ok       (supply_ok),
        .trims           (trims),
        .levels          (levels),
        .lanes_active    (lanes_active)
    );

    test_bus_mux u_test_bus_mux (
        .clkin_binary_0  (clkin_binary_0),
        .clkinb_binary_0 (clkinb_binary_0),
        .meas            (meas),
        .atb_ena         (atb_ena),
        .pdb             (pdb),
        .supply_ok       (supply_ok),
        .atb             (atb),
        .atb_valid       (atb_valid)
    );

endmodule

`default_nettype wire

/* bench/rsync_props.sv */
`timescale 1ns/1ps
`default_nettype none

module rsync_props import rsync_pkg::*; (
    input wire logic          clkin_binary_0,
    input wire logic          clkinb_binary_0,
    input wire logic          pdb,
    input wire logic          supply_ok,
    input wire drive_levels_t levels,
    input wire logic          lanes_active
);

    // Supplies out of window freeze the switches
    hold_on_bad_supply: assert property (@(posedge clkin_binary_0) disable iff (!clkinb_binary_0)
        (pdb && !supply_ok) |=> ($stable(levels) && $stable(lanes_active)))
        else $error("levels moved while supplies were out of window");

    power_down_clears: assert property (@(posedge clkin_binary_0) disable iff (!clkinb_binary_0)
        !pdb |=> (levels == '0 && !lanes_active))
        else $error("levels not cleared after power-down");

    active_needs_pdb: assert property (@(posedge clkin_binary_0) disable iff (!clkinb_binary_0)
        lanes_active |-> $past(pdb))
        else $error("lanes_active without pdb on previous edge");

endmodule

bind lane_latch_bank rsync_props u_props (
    .clkin_binary_0  (clkin_binary_0),
    .clkinb_binary_0 (clkinb_binary_0),
    .pdb             (pdb),
    .supply_ok       (supply_ok),
    .levels          (levels),
    .lanes_active    (lanes_active)
);

`default_nettype wire

/* bench/rsync_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rsync_tb import rsync_pkg::*; ();

    logic          clk;
    logic          rstn;
    lane_word_u    data_in;
    lane_word_u    data_in_b;
    logic          pdb;
    supply_meas_t  meas;
    trim_wr_t      trim_wr;
    logic [1:0]    atb_ena;
    drive_levels_t levels;
    logic          lanes_active;
    logic          supply_ok;
    atb_t          atb;
    logic          atb_valid;

    logic signed [5:0] model_trims [0:47];     // Slot 0-23 true lanes, 24-47 complement
    lane_word_u        last_w;
    lane_word_u        last_wb;
    int                errors;
    int                tests_run;
    int                test_start;

    rsync_top DUT (
        .clkin_binary_0  (clk),
        .clkinb_binary_0 (rstn),
        .data_in         (data_in),
        .data_in_b       (data_in_b),
        .pdb             (pdb),
        .meas            (meas),
        .trim_wr         (trim_wr),
        .atb_ena         (atb_ena),
        .levels          (levels),
        .lanes_active    (lanes_active),
        .supply_ok       (supply_ok),
        .atb             (atb),
        .atb_valid       (atb_valid)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Unit plus sign-extended trim for a set bit
    function automatic logic [7:0] expected_level(input logic b, input logic signed [5:0] tr);
        logic signed [8:0] sum;
        sum = 9'sd128 + tr;
        return b ? sum[7:0] : 8'd0;
    endfunction

    function automatic logic [7:0] dut_level(input bit comp, input int k);
        if (k < 7) begin
            return comp ? levels.bin_b[k] : levels.bin[k];
        end
        return comp ? levels.therm_b[k-7] : levels.therm[k-7];
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("ERR %0t %s expected %0h got %0h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic begin_test();
        test_start = errors;
        tests_run++;
    endtask

    task automatic end_test(input string name);
        if (errors == test_start) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - test_start);
        end
    endtask

    // Compare all 48 lanes with the last latched words, or with zero when off
    task automatic check_levels(input bit on);
        for (int k = 0; k < 24; k++) begin
            check_val($sformatf("levels lane %0d", k),
                      on ? expected_level(last_w.flat[k], model_trims[k]) : 8'd0,
                      dut_level(0, k));
            check_val($sformatf("levels_b lane %0d", k),
                      on ? expected_level(last_wb.flat[k], model_trims[24+k]) : 8'd0,
                      dut_level(1, k));
        end
        check_val("lanes_active", 32'(on), lanes_active);
    endtask

    task automatic apply_word(input bit hold);
        @(posedge clk);
        data_in.flat   <= 24'($urandom);
        data_in_b.flat <= 24'($urandom);
        @(posedge clk);
        if (!hold) begin
            last_w  = data_in;
            last_wb = data_in_b;
        end
        @(negedge clk);
    endtask

    task automatic set_meas(input int vdd, input int vss, input int iref);
        @(posedge clk);
        meas.vdd_code  <= 10'(vdd);
        meas.vss_code  <= 10'(vss);
        meas.iref_code <= 10'(iref);
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic wait_supply_ok();
        int n;
        n = 0;
        while (supply_ok !== 1'b1) begin
            @(negedge clk);
            n++;
            if (n > 20) begin
                $display("Timed out waiting for supply_ok to rise");
                $display("TESTS FAILED");
                $finish;
            end
        end
    endtask

    task automatic write_trim(input logic [5:0] addr, input logic signed [5:0] val);
        @(posedge clk);
        trim_wr.wr   <= 1'b1;
        trim_wr.addr <= addr;
        trim_wr.data <= val;
        @(posedge clk);
        trim_wr.wr <= 1'b0;
        if (addr < 24) begin
            model_trims[addr] = val;
        end else if (addr >= 32 && addr < 56) begin
            model_trims[addr - 8] = val;
        end
    endtask

    task automatic test_reset();
        begin_test();
        check_levels(0);
        check_val("supply_ok", 0, supply_ok);
        check_val("atb", 0, atb);
        check_val("atb_valid", 0, atb_valid);
        end_test("reset");
    endtask

    task automatic test_nominal();
        begin_test();
        set_meas(800, 0, 250);
        wait_supply_ok();
        repeat (8) begin
            apply_word(0);
            check_levels(1);
        end
        end_test("nominal");
    endtask

    task automatic test_trim();
        logic [5:0] addrs [0:5];
        begin_test();
        addrs = '{6'd0, 6'd23, 6'd32, 6'd55, 6'd5, 6'd40};
        foreach (addrs[i]) begin
            write_trim(addrs[i], 6'($urandom));
        end
        write_trim(6'd28, 6'sd17);                 // Hole in the map
        write_trim(6'd60, -6'sd9);
        repeat (6) begin
            apply_word(0);
            check_levels(1);
        end
        end_test("trim");
    endtask

    task automatic test_power_down();
        begin_test();
        @(posedge clk);
        pdb <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_levels(0);
        @(posedge clk);
        pdb <= 1'b1;
        repeat (3) begin
            apply_word(0);
            check_levels(1);
        end
        end_test("power_down");
    endtask

    task automatic test_supply_window();
        int steps [0:11][0:3];
        begin_test();
        // vdd, vss, iref, expected ok
        steps = '{'{760, 0, 250, 1}, '{759, 0, 250, 0}, '{840, 0, 250, 1}, '{841, 0, 250, 0},
                  '{800, -50, 250, 1}, '{800, -51, 250, 0}, '{800, 50, 250, 1},
                  '{800, 51, 250, 0}, '{800, 0, 225, 1}, '{800, 0, 224, 0},
                  '{800, 0, 275, 1}, '{800, 0, 276, 0}};
        for (int i = 0; i < 12; i++) begin
            set_meas(steps[i][0], steps[i][1], steps[i][2]);
            check_val($sformatf("supply_ok step %0d", i), steps[i][3], supply_ok);
            apply_word(steps[i][3] == 0);
            check_levels(1);
        end
        set_meas(800, 0, 250);
        end_test("supply_window");
    endtask

    task automatic check_atb(input logic [9:0] a1, input logic [9:0] a0, input logic v);
        check_val("atb.atb1", a1, atb.atb1);
        check_val("atb.atb0", a0, atb.atb0);
        check_val("atb_valid", v, atb_valid);
    endtask

    task automatic test_bus();
        begin_test();
        set_meas(810, -20, 240);                   // Distinct nonzero readings on every leg
        for (int c = 0; c < 4; c++) begin
            @(posedge clk);
            atb_ena <= 2'(c);
            @(posedge clk);
            @(negedge clk);
            if (2'(c) == atb_off) begin
                check_atb(0, 0, 0);
            end else if (2'(c) == atb_iref) begin
                check_atb(10'd240, 10'd240, 1);
            end else begin
                check_atb(10'd810, 10'(-20), 1);
            end
        end
        @(posedge clk);
        atb_ena <= atb_vdd_vss_a;
        pdb     <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_atb(0, 0, 0);
        @(posedge clk);
        pdb           <= 1'b1;
        meas.vdd_code <= 10'd900;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_atb(0, 0, 0);
        set_meas(800, 0, 250);
        end_test("test_bus");
    endtask

    initial begin
        void'($urandom(32'hd65));
        errors     = 0;
        tests_run  = 0;
        rstn       = 1'b0;
        data_in    = '0;
        data_in_b  = '0;
        pdb        = 1'b1;
        meas       = '0;
        trim_wr    = '0;
        atb_ena    = atb_off;
        last_w     = '0;
        last_wb    = '0;
        for (int i = 0; i < 48; i++) begin
            model_trims[i] = '0;
        end
        repeat (5) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        test_reset();
        test_nominal();
        test_trim();
        test_power_down();
        test_supply_window();
        test_bus();
        $display("%0d tests run, %0d errors", tests_run, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
design/rsync_pkg.sv
design/supply_monitor.sv
design/trim_table.sv
design/lane_latch_bank.sv
design/test_bus_mux.sv
design/rsync_top.sv
bench/rsync_props.sv
bench/rsync_tb.sv
